// ==== source/icache_defines.svh ====
`ifndef ICACHE_DEFINES_SVH
`define ICACHE_DEFINES_SVH

// ##################################################
// fetch port widths
// ##################################################

`define ICACHE_ADDR_W 32
`define ICACHE_WORD_W 32

// ##################################################
// cache geometry
// ##################################################

`define ICACHE_LINES 16
`define ICACHE_OFFSET_W 2                   // byte offset inside a word.
`define ICACHE_INDEX_W $clog2(`ICACHE_LINES)
`define ICACHE_TAG_W (`ICACHE_ADDR_W - `ICACHE_INDEX_W - `ICACHE_OFFSET_W)

`endif

// ==== source/fetch_bus_pkg.sv ====
`include "icache_defines.svh"

package fetch_bus_pkg;

    typedef logic [`ICACHE_ADDR_W-1:0] fetch_addr_t;
    typedef logic [`ICACHE_WORD_W-1:0] fetch_word_t;

    // ##################################################
    // core side
    // ##################################################

    typedef struct packed {
        logic        valid;                 // held until the response strobe.
        fetch_addr_t addr;
    } cpu_req_t;

    typedef struct packed {
        logic        valid;                 // one cycle wide.
        fetch_word_t data;
    } cpu_rsp_t;

    // ##################################################
    // memory side
    // ##################################################

    typedef struct packed {
        logic        valid;                 // held until ready.
        fetch_addr_t addr;                  // word aligned.
    } mem_req_t;

    typedef struct packed {
        logic        ready;
        fetch_word_t data;                  // valid together with ready.
    } mem_rsp_t;

endpackage

// ==== source/icache_pkg.sv ====
`include "icache_defines.svh"

package icache_pkg;

    // address split is tag | index | byte offset.
    typedef logic [`ICACHE_INDEX_W-1:0] line_index_t;
    typedef logic [`ICACHE_TAG_W-1:0]   line_tag_t;

    typedef struct packed {
        logic      valid;
        line_tag_t tag;
    } tag_entry_t;

    // ##################################################
    // controller states
    // ##################################################

    typedef enum logic [1:0] {
        IDLE,                               // waiting for a fetch.
        LOOKUP,                             // store outputs are valid here.
        REFILL                              // waiting on memory.
    } ctrl_state_e;

endpackage

// ==== source/icache_tag_store.sv ====
`include "icache_defines.svh"

module icache_tag_store (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    flush,
    input  icache_pkg::line_index_t rd_index,
    output icache_pkg::tag_entry_t  rd_entry,
    input  logic                    wr_en,
    input  icache_pkg::line_index_t wr_index,
    input  icache_pkg::line_tag_t   wr_tag
);
    import icache_pkg::*;

    logic [`ICACHE_LINES-1:0] valid_q;
    line_tag_t                tag_q [`ICACHE_LINES];

    // ##################################################
    // valid bits
    // ##################################################

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            valid_q <= '0;
        end
        else
        begin
            if (flush)
                valid_q <= '0;
            if (wr_en)
                valid_q[wr_index] <= 1'b1;  // refill beats a flush on its own line.
        end
    end

    // ##################################################
    // tags and read port
    // ##################################################

    always_ff @(posedge clk)
    begin
        if (wr_en)
            tag_q[wr_index] <= wr_tag;
    end

    always_ff @(posedge clk)
    begin
        rd_entry.valid <= valid_q[rd_index];
        rd_entry.tag   <= tag_q[rd_index];
    end

endmodule

// ==== source/icache_data_store.sv ====
`include "icache_defines.svh"

module icache_data_store (
    input  logic                       clk,
    input  icache_pkg::line_index_t    rd_index,
    output fetch_bus_pkg::fetch_word_t rd_word,
    input  logic                       wr_en,
    input  icache_pkg::line_index_t    wr_index,
    input  fetch_bus_pkg::fetch_word_t wr_word
);
    import fetch_bus_pkg::*;

    // one word per line, read beside the tag store.
    fetch_word_t word_q [`ICACHE_LINES];

    always_ff @(posedge clk)
    begin
        if (wr_en)
            word_q[wr_index] <= wr_word;
    end

    always_ff @(posedge clk)
    begin
        rd_word <= word_q[rd_index];        // valid one cycle after the index.
    end

endmodule

// ==== source/icache_controller.sv ====
`include "icache_defines.svh"

module icache_controller (
    input  logic                       clk,
    input  logic                       rst,
    input  fetch_bus_pkg::cpu_req_t    cpu_req,
    output fetch_bus_pkg::cpu_rsp_t    cpu_rsp,
    output fetch_bus_pkg::mem_req_t    mem_req,
    input  fetch_bus_pkg::mem_rsp_t    mem_rsp,
    output icache_pkg::line_index_t    rd_index,
    input  icache_pkg::tag_entry_t     rd_entry,
    input  fetch_bus_pkg::fetch_word_t rd_word,
    output logic                       wr_en,
    output icache_pkg::line_index_t    wr_index,
    output icache_pkg::line_tag_t      wr_tag,
    output fetch_bus_pkg::fetch_word_t wr_word
);
    import fetch_bus_pkg::*;
    import icache_pkg::*;

    ctrl_state_e state_q;
    ctrl_state_e state_d;
    fetch_addr_t addr_q;
    line_index_t addr_index;
    line_tag_t   addr_tag;
    logic        accept;
    logic        lookup_hit;
    logic        lookup_miss;
    logic        refill_done;

    logic        rsp_valid_q;
    fetch_word_t rsp_data_q;
    logic        req_valid_q;
    fetch_addr_t req_addr_q;

    // ##################################################
    // decode
    // ##################################################

    assign addr_index = addr_q[`ICACHE_OFFSET_W +: `ICACHE_INDEX_W];
    assign addr_tag   = addr_q[`ICACHE_ADDR_W-1 -: `ICACHE_TAG_W];

    // the request is still up during the strobe cycle, so skip it once.
    assign accept = (state_q == IDLE) && cpu_req.valid && !rsp_valid_q;

    assign lookup_hit  = (state_q == LOOKUP) && rd_entry.valid && (rd_entry.tag == addr_tag);
    assign lookup_miss = (state_q == LOOKUP) && !lookup_hit;
    assign refill_done = (state_q == REFILL) && mem_rsp.ready;

    // in IDLE the stores look at the incoming address directly.
    assign rd_index = (state_q == IDLE) ? cpu_req.addr[`ICACHE_OFFSET_W +: `ICACHE_INDEX_W]
                                        : addr_index;

    // ##################################################
    // state machine
    // ##################################################

    always_comb
    begin
        state_d = state_q;
        case (state_q)
            IDLE:
            begin
                if (accept)
                    state_d = LOOKUP;
            end
            LOOKUP:
            begin
                state_d = lookup_hit ? IDLE : REFILL;
            end
            REFILL:
            begin
                if (mem_rsp.ready)
                    state_d = IDLE;
            end
            default:
            begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state_q     <= IDLE;
            rsp_valid_q <= 1'b0;
            req_valid_q <= 1'b0;
        end
        else
        begin
            state_q     <= state_d;
            rsp_valid_q <= lookup_hit || refill_done;
            if (lookup_miss)
                req_valid_q <= 1'b1;
            else if (refill_done)
                req_valid_q <= 1'b0;
        end
    end

    // ##################################################
    // address and data registers
    // ##################################################

    always_ff @(posedge clk)
    begin
        if (accept)
            addr_q <= cpu_req.addr;
        if (lookup_miss)
            req_addr_q <= {addr_q[`ICACHE_ADDR_W-1:`ICACHE_OFFSET_W], {`ICACHE_OFFSET_W{1'b0}}};
        if (lookup_hit)
            rsp_data_q <= rd_word;
        else if (refill_done)
            rsp_data_q <= mem_rsp.data;     // forwarded while it is written.
    end

    assign cpu_rsp = '{valid: rsp_valid_q, data: rsp_data_q};
    assign mem_req = '{valid: req_valid_q, addr: req_addr_q};

    // refill write goes to both stores on the ready edge.
    assign wr_en    = refill_done;
    assign wr_index = addr_index;
    assign wr_tag   = addr_tag;
    assign wr_word  = mem_rsp.data;

endmodule

// ==== source/icache_top.sv ====
module icache_top (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    flush,
    input  fetch_bus_pkg::cpu_req_t cpu_req,
    output fetch_bus_pkg::cpu_rsp_t cpu_rsp,
    output fetch_bus_pkg::mem_req_t mem_req,
    input  fetch_bus_pkg::mem_rsp_t mem_rsp
);
    import fetch_bus_pkg::*;
    import icache_pkg::*;

    line_index_t rd_index;
    tag_entry_t  rd_entry;
    fetch_word_t rd_word;
    logic        wr_en;
    line_index_t wr_index;
    line_tag_t   wr_tag;
    fetch_word_t wr_word;

    icache_tag_store i_tag_store (
        .clk      (clk),
        .rst      (rst),
        .flush    (flush),
        .rd_index (rd_index),
        .rd_entry (rd_entry),
        .wr_en    (wr_en),
        .wr_index (wr_index),
        .wr_tag   (wr_tag)
    );

    icache_data_store i_data_store (
        .clk      (clk),
        .rd_index (rd_index),
        .rd_word  (rd_word),
        .wr_en    (wr_en),
        .wr_index (wr_index),
        .wr_word  (wr_word)
    );

    icache_controller i_controller (
        .clk      (clk),
        .rst      (rst),
        .cpu_req  (cpu_req),
        .cpu_rsp  (cpu_rsp),
        .mem_req  (mem_req),
        .mem_rsp  (mem_rsp),
        .rd_index (rd_index),
        .rd_entry (rd_entry),
        .rd_word  (rd_word),
        .wr_en    (wr_en),
        .wr_index (wr_index),
        .wr_tag   (wr_tag),
        .wr_word  (wr_word)
    );

endmodule

// ==== dv/icache_tb.sv ====
module icache_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import fetch_bus_pkg::*;

    localparam int TIMEOUT_CYCLES = 50;
    localparam int HIT_CYCLES     = 2;          // sampling edge to visible strobe.

    logic     clk = 1'b0;
    logic     rst;
    logic     flush;
    cpu_req_t cpu_req;
    cpu_rsp_t cpu_rsp;
    mem_req_t mem_req;
    mem_rsp_t mem_rsp;

    integer      seed     = 32'ha56d72bf;
    int          errors   = 0;
    int          passed   = 0;
    int          failed   = 0;
    logic        abort    = 1'b0;
    int          mem_count = 0;
    logic        mem_busy = 1'b0;
    int          mem_wait = 0;
    fetch_addr_t mem_addr = '0;
    mem_rsp_t    mem_next = '0;

    icache_top i_dut (
        .clk     (clk),
        .rst     (rst),
        .flush   (flush),
        .cpu_req (cpu_req),
        .cpu_rsp (cpu_rsp),
        .mem_req (mem_req),
        .mem_rsp (mem_rsp)
    );

    always #20 clk = ~clk;

    // ##################################################
    // memory model
    // ##################################################

    always @(posedge clk)
    begin
        mem_rsp <= mem_next;
    end

    // watches the request at the falling edge, where it is stable.
    always @(negedge clk)
    begin
        if (rst)
        begin
            mem_busy = 1'b0;
            mem_next = '0;
        end
        else if (mem_busy)
        begin
            if (mem_req.valid !== 1'b1)
            begin
                $display("ERROR t=%0t mem_req.valid got %b expected 1", $time, mem_req.valid);
                errors++;
            end
            else if (mem_req.addr !== mem_addr)
            begin
                $display("ERROR t=%0t mem_req.addr got %h expected %h",
                         $time, mem_req.addr, mem_addr);
                errors++;
            end
            if (mem_rsp.ready)
            begin
                mem_busy = 1'b0;                // word is taken at the next edge.
                mem_next = '0;
            end
            else if (mem_wait > 1)
                mem_wait--;
            else
                mem_next = '{ready: 1'b1, data: ~mem_addr};
        end
        else if (mem_req.valid)
        begin
            mem_busy = 1'b1;
            mem_addr = mem_req.addr;
            mem_count++;
            mem_wait = 1 + ({$random(seed)} % 4);  // 1 to 4 cycles.
        end
    end

    // ##################################################
    // helpers
    // ##################################################

    function automatic fetch_addr_t word_address(input fetch_addr_t addr);
        return addr & 32'hffff_fffc;
    endfunction

    task automatic report_test(input int index, input string what, input int start_errors);
        if (errors == start_errors)
        begin
            passed++;
            $display("test %0d %s ok", index, what);
        end
        else
        begin
            failed++;
            $display("test %0d %s failed", index, what);
        end
    endtask

    task automatic check_reset_state();
        int start_errors;
        start_errors = errors;
        @(negedge clk);
        if (cpu_rsp.valid !== 1'b0)
        begin
            $display("ERROR t=%0t cpu_rsp.valid got %b expected 0", $time, cpu_rsp.valid);
            errors++;
        end
        if (mem_req.valid !== 1'b0)
        begin
            $display("ERROR t=%0t mem_req.valid got %b expected 0", $time, mem_req.valid);
            errors++;
        end
        report_test(0, "reset", start_errors);
    endtask

    task automatic run_flush(input int index);
        int start_errors;
        start_errors = errors;
        @(posedge clk);
        flush <= 1'b1;
        @(posedge clk);
        flush <= 1'b0;
        @(negedge clk);
        // a flush alone starts no fetch.
        if (cpu_rsp.valid !== 1'b0)
        begin
            $display("ERROR t=%0t cpu_rsp.valid got %b expected 0", $time, cpu_rsp.valid);
            errors++;
        end
        if (mem_req.valid !== 1'b0)
        begin
            $display("ERROR t=%0t mem_req.valid got %b expected 0", $time, mem_req.valid);
            errors++;
        end
        report_test(index, "flush", start_errors);
    endtask

    task automatic run_fetch(input int index, input fetch_addr_t addr,
                             input fetch_word_t exp_data, input int exp_miss);
        int   start_errors;
        int   start_reqs;
        int   waited;
        logic got;
        start_errors = errors;
        start_reqs   = mem_count;
        waited       = 0;
        got          = 1'b0;
        @(posedge clk);
        cpu_req <= '{valid: 1'b1, addr: addr};
        while (!got && waited < TIMEOUT_CYCLES)
        begin
            @(negedge clk);
            waited++;
            got = cpu_rsp.valid;
        end
        if (!got)
        begin
            $display("test %0d fetch of %h got no response within %0d cycles",
                     index, addr, TIMEOUT_CYCLES);
            errors++;
            abort = 1'b1;
        end
        else
        begin
            if (cpu_rsp.data !== exp_data)
            begin
                $display("ERROR t=%0t cpu_rsp.data got %h expected %h",
                         $time, cpu_rsp.data, exp_data);
                errors++;
            end
            if (exp_miss == 0 && waited - 1 != HIT_CYCLES)
            begin
                $display("ERROR t=%0t cpu_rsp.valid delay got %0d expected %0d",
                         $time, waited - 1, HIT_CYCLES);
                errors++;
            end
            if (mem_count - start_reqs != exp_miss)
            begin
                $display("ERROR t=%0t mem_req count got %0d expected %0d",
                         $time, mem_count - start_reqs, exp_miss);
                errors++;
            end
            if (exp_miss != 0 && mem_addr !== word_address(addr))
            begin
                $display("ERROR t=%0t mem_req.addr got %h expected %h",
                         $time, mem_addr, word_address(addr));
                errors++;
            end
            // the memory request ends on the edge that returns the word.
            if (mem_req.valid !== 1'b0)
            begin
                $display("ERROR t=%0t mem_req.valid got %b expected 0", $time, mem_req.valid);
                errors++;
            end
            @(posedge clk);
            cpu_req.valid <= 1'b0;              // drop after the strobe edge.
            @(negedge clk);
            if (cpu_rsp.valid !== 1'b0)
            begin
                $display("ERROR t=%0t cpu_rsp.valid got %b expected 0", $time, cpu_rsp.valid);
                errors++;
            end
        end
        report_test(index, "fetch", start_errors);
    endtask

    // ##################################################
    // pattern sequence
    // ##################################################

    initial
    begin
        int          fd;
        int          code;
        int          ch;
        int          index;
        logic [7:0]  op_code;
        fetch_addr_t addr;
        fetch_word_t exp_data;
        int          exp_miss;
        rst     = 1'b1;
        flush   = 1'b0;
        cpu_req = '0;
        mem_rsp = '0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        check_reset_state();
        fd = $fopen("dv/icache_patterns.txt", "r");
        if (fd == 0)
        begin
            $display("could not open the pattern file dv/icache_patterns.txt");
            errors++;
        end
        else
        begin
            index = 0;
            code  = $fscanf(fd, " %c", op_code);
            while (code == 1 && !abort)
            begin
                if (op_code == "#")
                begin
                    ch = $fgetc(fd);
                    while (ch != 10 && ch != -1)
                        ch = $fgetc(fd);
                end
                else
                begin
                    code = $fscanf(fd, "%h %h %d", addr, exp_data, exp_miss);
                    index++;
                    if (code != 3)
                    begin
                        $display("pattern line %0d is malformed", index);
                        errors++;
                        abort = 1'b1;
                    end
                    else if (op_code == "X")
                        run_flush(index);
                    else if (op_code == "F")
                        run_fetch(index, addr, exp_data, exp_miss);
                    else
                    begin
                        $display("pattern line %0d has an unknown operation", index);
                        errors++;
                    end
                end
                code = $fscanf(fd, " %c", op_code);
            end
            $fclose(fd);
        end
        $display("tests passed %0d failed %0d", passed, failed);
        if (failed == 0 && errors == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

endmodule

// ==== project.f ====
+incdir+source
source/fetch_bus_pkg.sv
source/icache_pkg.sv
source/icache_tag_store.sv
source/icache_data_store.sv
source/icache_controller.sv
source/icache_top.sv
dv/icache_tb.sv

// ==== Bender.yml ====
package:
  name: icache

sources:
  - include_dirs:
      - source
    files:
      - source/fetch_bus_pkg.sv
      - source/icache_pkg.sv
      - source/icache_tag_store.sv
      - source/icache_data_store.sv
      - source/icache_controller.sv
      - source/icache_top.sv
  - target: test
    files:
      - dv/icache_tb.sv

// ==== dv/icache_patterns.txt ====
# op addr(hex) expected_data(hex) expected_miss(1 = memory request)
# F = fetch, X = flush (addr, data and miss unused for X)
F 00001004 ffffeffb 1
F 00001004 ffffeffb 0
F 00001004 ffffeffb 0
F 00001008 ffffeff7 1
F 00001008 ffffeff7 0
F 00001006 ffffeffb 0
F 00002004 ffffdffb 1
F 00001008 ffffeff7 0
F 00001004 ffffeffb 1
F 00002004 ffffdffb 1
F 00002004 ffffdffb 0
F 0000103c ffffefc3 1
F 00000000 ffffffff 1
F 80000040 7fffffbf 1
F 00000000 ffffffff 1
F deadbeec 21524113 1
F deadbeec 21524113 0
X 00000000 00000000 0
F 00002004 ffffdffb 1
F 00001008 ffffeff7 1
F 00002004 ffffdffb 0
F 0000103c ffffefc3 1
F deadbeec 21524113 1
F deadbeec 21524113 0
X 00000000 00000000 0
F 00001004 ffffeffb 1
